/* filelist.f */
+incdir+hw
hw/router_pkg.sv
hw/next_tile_fifo_arb.sv
hw/tile_fifo.sv
hw/output_arb.sv
hw/router.sv
hw/mini_core_tile.sv
tests/tile_clkgen.sv
tests/tile_checker.sv
tests/tile_tb.sv

/* hw/mini_core_tile.sv */
// no core inside; the local port is external and its lookahead field is always recomputed here
module mini_core_tile
    import router_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  t_tile_id        local_tile_id,
    // ============================================================
    // fabric side
    // ============================================================
    input  logic            in_north_req_valid,
    input  var t_tile_trans in_north_req,
    output t_fab_ready      out_north_ready,
    output logic            out_north_req_valid,
    output t_tile_trans     out_north_req,
    input  var t_fab_ready  in_north_ready,
    input  logic            in_east_req_valid,
    input  var t_tile_trans in_east_req,
    output t_fab_ready      out_east_ready,
    output logic            out_east_req_valid,
    output t_tile_trans     out_east_req,
    input  var t_fab_ready  in_east_ready,
    input  logic            in_south_req_valid,
    input  var t_tile_trans in_south_req,
    output t_fab_ready      out_south_ready,
    output logic            out_south_req_valid,
    output t_tile_trans     out_south_req,
    input  var t_fab_ready  in_south_ready,
    input  logic            in_west_req_valid,
    input  var t_tile_trans in_west_req,
    output t_fab_ready      out_west_ready,
    output logic            out_west_req_valid,
    output t_tile_trans     out_west_req,
    input  var t_fab_ready  in_west_ready,
    // ============================================================
    // local core side
    // ============================================================
    input  logic            in_local_req_valid,
    input  var t_tile_trans in_local_req,    // lookahead field ignored
    output t_fab_ready      out_local_ready,
    output logic            out_local_req_valid,
    output t_tile_trans     out_local_req,
    input  var t_fab_ready  in_local_ready
);

    t_cardinal   first_hop;   // lane to use inside this router
    t_tile_trans local_req;

    // XY at this tile from the address tile field
    next_tile_fifo_arb #(
        .NEXT_TILE_CARDINAL (LOCAL)
    ) u_local_lookahead (
        .local_tile_id (local_tile_id),
        .dest_tile     (in_local_req.address.fields.tile),
        .next_card     (first_hop)
    );

    always_comb begin
        local_req                       = in_local_req;
        local_req.next_tile_fifo_arb_id = first_hop;  // core needs no routing knowledge
    end

    // remaining ports map by name
    router u_router (
        .*,
        .in_local_req (local_req)
    );

endmodule

/* hw/next_tile_fifo_arb.sv */
// pure XY rule; a step off the mesh edge keeps the own id, so routes must stay inside the mesh
`include "router_defs.svh"

module next_tile_fifo_arb
    import router_pkg::*;
#(
    parameter t_cardinal NEXT_TILE_CARDINAL = LOCAL  // direction the transaction leaves by
) (
    input  t_tile_id  local_tile_id,
    input  t_tile_id  dest_tile,
    output t_cardinal next_card
);

    localparam logic [`TILE_COORD_W-1:0] ROW_LAST = `TILE_COORD_W'(`MESH_ROWS - 1);
    localparam logic [`TILE_COORD_W-1:0] COL_LAST = `TILE_COORD_W'(`MESH_COLS - 1);

    t_tile_id nbr_id;  // tile that will receive the transaction

    // ============================================================
    // neighbour id, one step toward the exit
    // ============================================================
    always_comb begin
        nbr_id = local_tile_id;
        case (NEXT_TILE_CARDINAL)
            NORTH: if (local_tile_id.row != '0) nbr_id.row = local_tile_id.row - 1'b1;
            SOUTH: if (local_tile_id.row != ROW_LAST) nbr_id.row = local_tile_id.row + 1'b1;
            EAST:  if (local_tile_id.col != COL_LAST) nbr_id.col = local_tile_id.col + 1'b1;
            WEST:  if (local_tile_id.col != '0) nbr_id.col = local_tile_id.col - 1'b1;
            default: ;  // LOCAL stays here
        endcase
    end

    // ============================================================
    // XY decision at the neighbour, columns first
    // ============================================================
    always_comb begin
        if (dest_tile.col != nbr_id.col) begin
            next_card = (dest_tile.col > nbr_id.col) ? EAST : WEST;
        end else if (dest_tile.row < nbr_id.row) begin
            next_card = NORTH;
        end else if (dest_tile.row > nbr_id.row) begin
            next_card = SOUTH;
        end else begin
            next_card = LOCAL;  // arrived
        end
    end

endmodule

/* hw/output_arb.sv */
// four lanes per output; loads one winner per cycle, holds it until the downstream ready bit is seen
module output_arb
    import router_pkg::*;
#(
    parameter t_cardinal OUT_CARD = LOCAL  // output this arbiter drives
) (
    input  logic              clk,
    input  logic              arst_n,
    input  t_tile_id          local_tile_id,
    input  logic        [3:0] lane_empty,
    input  t_tile_trans [3:0] lane_head,
    output logic        [3:0] lane_pop,
    output logic              out_req_valid,
    output t_tile_trans       out_req,
    input  t_fab_ready        in_ready
);

    logic [1:0] rr_ptr;     // lane with top priority
    logic [1:0] gnt_idx;
    logic       gnt_any;
    logic [4:0] rdy_vec;    // indexed by t_cardinal
    logic       xfer;
    logic       load;
    t_cardinal  route_card;
    t_cardinal  new_card;

    // ============================================================
    // round robin pick
    // ============================================================
    always_comb begin
        logic [1:0] idx;
        gnt_any = 1'b0;
        gnt_idx = rr_ptr;
        // walk backwards so the nearest non-empty lane wins
        for (int i = 3; i >= 0; i--) begin
            idx = rr_ptr + 2'(i);
            if (!lane_empty[idx]) begin
                gnt_any = 1'b1;
                gnt_idx = idx;
            end
        end
    end

    assign rdy_vec = in_ready;
    assign xfer    = out_req_valid && rdy_vec[out_req.next_tile_fifo_arb_id];
    assign load    = gnt_any && (!out_req_valid || xfer);  // reg free or draining now

    always_comb begin
        lane_pop = '0;
        if (load) lane_pop[gnt_idx] = 1'b1;
    end

    // ============================================================
    // lookahead for the hop after this one
    // ============================================================
    next_tile_fifo_arb #(
        .NEXT_TILE_CARDINAL (OUT_CARD)
    ) u_lookahead (
        .local_tile_id (local_tile_id),
        .dest_tile     (lane_head[gnt_idx].address.fields.tile),
        .next_card     (route_card)
    );

    assign new_card = (OUT_CARD == LOCAL) ? LOCAL : route_card;  // core needs no route

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_req_valid <= 1'b0;
            rr_ptr        <= '0;
        end else if (load) begin
            out_req_valid <= 1'b1;
            rr_ptr        <= gnt_idx + 1'b1;  // winner drops to last
        end else if (xfer) begin
            out_req_valid <= 1'b0;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (load) begin
            out_req                       <= lane_head[gnt_idx];
            out_req.next_tile_fifo_arb_id <= new_card;
        end
    end

endmodule

/* hw/router.sv */
// five ports, no U-turns: a lane from a port back to the same port does not exist and its ready is 0
module router
    import router_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  t_tile_id        local_tile_id,
    // north
    input  logic            in_north_req_valid,
    input  var t_tile_trans in_north_req,
    output t_fab_ready      out_north_ready,
    output logic            out_north_req_valid,
    output t_tile_trans     out_north_req,
    input  var t_fab_ready  in_north_ready,
    // east
    input  logic            in_east_req_valid,
    input  var t_tile_trans in_east_req,
    output t_fab_ready      out_east_ready,
    output logic            out_east_req_valid,
    output t_tile_trans     out_east_req,
    input  var t_fab_ready  in_east_ready,
    // south
    input  logic            in_south_req_valid,
    input  var t_tile_trans in_south_req,
    output t_fab_ready      out_south_ready,
    output logic            out_south_req_valid,
    output t_tile_trans     out_south_req,
    input  var t_fab_ready  in_south_ready,
    // west
    input  logic            in_west_req_valid,
    input  var t_tile_trans in_west_req,
    output t_fab_ready      out_west_ready,
    output logic            out_west_req_valid,
    output t_tile_trans     out_west_req,
    input  var t_fab_ready  in_west_ready,
    // local
    input  logic            in_local_req_valid,
    input  var t_tile_trans in_local_req,
    output t_fab_ready      out_local_ready,
    output logic            out_local_req_valid,
    output t_tile_trans     out_local_req,
    input  var t_fab_ready  in_local_ready
);

    // ============================================================
    // ports gathered into arrays, index = t_cardinal
    // ============================================================
    logic        [4:0]      in_valid;
    t_tile_trans [4:0]      in_req_a;
    t_fab_ready  [4:0]      in_rdy;     // downstream readiness per output
    logic        [4:0][4:0] rdy_out;    // [input port][output arbiter]
    logic        [4:0]      out_valid;
    t_tile_trans [4:0]      out_req_a;

    assign in_valid = {in_local_req_valid, in_west_req_valid, in_south_req_valid,
                       in_east_req_valid, in_north_req_valid};
    assign in_req_a = {in_local_req, in_west_req, in_south_req, in_east_req, in_north_req};
    assign in_rdy   = {in_local_ready, in_west_ready, in_south_ready,
                       in_east_ready, in_north_ready};

    assign {out_local_ready, out_west_ready, out_south_ready,
            out_east_ready, out_north_ready} = rdy_out;
    assign {out_local_req_valid, out_west_req_valid, out_south_req_valid,
            out_east_req_valid, out_north_req_valid} = out_valid;
    assign {out_local_req, out_west_req, out_south_req,
            out_east_req, out_north_req} = out_req_a;

    // no lane back out the same port
    for (genvar p = 0; p < 5; p++) begin : g_no_uturn
        assign rdy_out[p][p] = 1'b0;
    end

    // ============================================================
    // per output: four lane fifos and one arbiter
    // ============================================================
    for (genvar o = 0; o < 5; o++) begin : g_out
        localparam t_cardinal OC = t_cardinal'(o);

        logic        [3:0] arb_empty;
        t_tile_trans [3:0] arb_head;
        logic        [3:0] arb_pop;

        for (genvar j = 0; j < 4; j++) begin : g_lane
            localparam int Q = (j < o) ? j : j + 1;  // skip input o itself

            logic push;
            logic full;

            // steer by the sender's lookahead
            assign push = in_valid[Q] && (in_req_a[Q].next_tile_fifo_arb_id == OC);

            tile_fifo u_fifo (
                .clk       (clk),
                .arst_n    (arst_n),
                .push      (push),
                .push_data (in_req_a[Q]),
                .full      (full),
                .pop       (arb_pop[j]),
                .pop_data  (arb_head[j]),
                .empty     (arb_empty[j])
            );

            assign rdy_out[Q][o] = !full;
        end

        output_arb #(
            .OUT_CARD (OC)
        ) u_arb (
            .clk           (clk),
            .arst_n        (arst_n),
            .local_tile_id (local_tile_id),
            .lane_empty    (arb_empty),
            .lane_head     (arb_head),
            .lane_pop      (arb_pop),
            .out_req_valid (out_valid[o]),
            .out_req       (out_req_a[o]),
            .in_ready      (in_rdy[o])
        );
    end

endmodule

/* hw/router_defs.svh */
// mesh is at most 4x4 with 2-bit coordinates; fifo depth must be a power of two, at least 2
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// ============================================================
// mesh geometry
// ============================================================
`define MESH_ROWS       4       // row 0 is the northmost
`define MESH_COLS       4       // col 0 is the westmost
`define TILE_COORD_W    2       // bits per row or column

// ============================================================
// buffering and field widths
// ============================================================
`define TILE_FIFO_DEPTH 2       // entries per input-to-output lane
`define CARD_W          3       // cardinal encoding
`define OPCODE_W        2
`define ADDR_W          32
`define ADDR_RSVD_W     4       // between tile id and offset
`define ADDR_OFFSET_W   24      // offset inside the target tile
`define DATA_W          32

`endif

/* hw/router_pkg.sv */
// field widths come from router_defs.svh; address tile id must fill bits 31:28
`include "router_defs.svh"

package router_pkg;

    // ============================================================
    // directions and tile coordinates
    // ============================================================
    typedef enum logic [`CARD_W-1:0] {
        NORTH = 3'd0,
        EAST  = 3'd1,
        SOUTH = 3'd2,
        WEST  = 3'd3,
        LOCAL = 3'd4
    } t_cardinal;

    typedef struct packed {
        logic [`TILE_COORD_W-1:0] row;  // grows southward
        logic [`TILE_COORD_W-1:0] col;  // grows eastward
    } t_tile_id;

    // ============================================================
    // address, two views of the same word
    // ============================================================
    typedef struct packed {
        t_tile_id                  tile;    // destination tile, bits 31:28
        logic [`ADDR_RSVD_W-1:0]   rsvd;
        logic [`ADDR_OFFSET_W-1:0] offset;
    } t_addr_fields;

    typedef union packed {
        logic [`ADDR_W-1:0] flat;    // core side view
        t_addr_fields       fields;  // router view
    } t_addr;

    typedef enum logic [`OPCODE_W-1:0] {
        RD = 2'b00,
        WR = 2'b01
    } t_opcode;

    // 73 bits on the wire
    typedef struct packed {
        t_opcode             opcode;
        t_addr               address;
        logic [`DATA_W-1:0]  data;
        t_tile_id            requestor;
        t_cardinal           next_tile_fifo_arb_id;  // output to take in the receiving tile
    } t_tile_trans;

    // local_arb is the msb, so bit index equals the t_cardinal value
    typedef struct packed {
        logic local_arb;
        logic west_arb;
        logic south_arb;
        logic east_arb;
        logic north_arb;
    } t_fab_ready;

endpackage

/* hw/tile_fifo.sv */
// depth from TILE_FIFO_DEPTH, power of two and at least 2; push when full and pop when empty are dropped
`include "router_defs.svh"

module tile_fifo
    import router_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        push,
    input  t_tile_trans push_data,
    output logic        full,
    input  logic        pop,
    output t_tile_trans pop_data,
    output logic        empty
);

    localparam int DEPTH = `TILE_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [PTR_W:0] wr_ptr;   // msb is the wrap bit
    logic [PTR_W:0] rd_ptr;
    logic           wr_en;
    logic           rd_en;
    t_tile_trans    mem [DEPTH];

    // same index, opposite wrap -> full
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign wr_en = push && !full;   // guarded, caller may push blindly
    assign rd_en = pop && !empty;

    assign pop_data = mem[rd_ptr[PTR_W-1:0]];  // head always visible

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // storage only
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[PTR_W-1:0]] <= push_data;
        end
    end

endmodule

/* tests/tile_checker.sv */
// bound into the router; relies on its per-port arrays indexed by t_cardinal and its ready ports
module tile_checker
    import router_pkg::*;
(
    input logic              clk,
    input logic              arst_n,
    input logic        [4:0] out_valid,
    input t_tile_trans [4:0] out_req_a,
    input logic   [4:0][4:0] in_rdy,    // downstream readiness per output
    input t_fab_ready        north_rdy, // ready vectors as they leave the router
    input t_fab_ready        east_rdy,
    input t_fab_ready        south_rdy,
    input t_fab_ready        west_rdy,
    input t_fab_ready        local_rdy
);
    timeunit 1ns;
    timeprecision 100ps;

    int n_fail = 0;  // failed assertion count

    // ============================================================
    // reset
    // ============================================================
    a_idle_in_reset: assert property (@(posedge clk) !arst_n |-> out_valid == '0)
        else begin
            n_fail++;
            $error("output valid high while reset is asserted");
        end

    // same-direction bit of each port, picked by field name
    a_no_uturn: assert property (@(posedge clk)
        !(north_rdy.north_arb || east_rdy.east_arb || south_rdy.south_arb ||
          west_rdy.west_arb || local_rdy.local_arb))
        else begin
            n_fail++;
            $error("a port offers a lane back to itself");
        end

    // ============================================================
    // per output handshake
    // ============================================================
    for (genvar o = 0; o < 5; o++) begin : g_port
        // not taken -> same request next cycle
        a_hold: assert property (@(posedge clk) disable iff (!arst_n)
            out_valid[o] && !in_rdy[o][out_req_a[o].next_tile_fifo_arb_id]
            |=> out_valid[o] && $stable(out_req_a[o]))
            else begin
                n_fail++;
                $error("output %0d dropped or changed an unaccepted request", o);
            end
    end

endmodule

bind router tile_checker checker_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .out_valid (out_valid),
    .out_req_a (out_req_a),
    .in_rdy    (in_rdy),
    .north_rdy (out_north_ready),
    .east_rdy  (out_east_ready),
    .south_rdy (out_south_ready),
    .west_rdy  (out_west_ready),
    .local_rdy (out_local_ready)
);

/* tests/tile_clkgen.sv */
// free running clock from time 0; reset is released a short delay after the last reset edge
module tile_clkgen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(PERIOD_NS / 10) arst_n = 1'b1;  // off the edge
    end

endmodule

/* tests/tile_input.txt */
// port opcode address data lookahead exit exit_lookahead, all hex, one record per line
// ports 0 north 1 east 2 south 3 west 4 local; lookahead of a local record is ignored
3 1 70000010 00001001 1 1 1
3 0 60000020 00001002 1 1 4
3 1 10000030 00001003 0 0 4
3 0 d0000040 00001004 2 2 2
3 1 50000050 00001005 4 4 4
1 0 40000060 00001006 3 3 4
1 1 90000070 00001007 2 2 4
1 0 50000080 00001008 4 4 4
0 1 d0000090 00001009 2 2 2
0 0 500000a0 0000100a 4 4 4
2 1 100000b0 0000100b 0 0 4
2 0 500000c0 0000100c 4 4 4
4 1 300000d0 0000100d 0 1 1
4 0 c00000e0 0000100e 2 3 2
4 1 100000f0 0000100f 3 0 4
4 0 d0000100 00001010 1 2 2
4 1 a0000110 00001011 4 1 2
3 0 b0000120 00001012 1 1 1

/* tests/tile_tb.sv */
// tile fixed at row 1, col 1; input file holds at most MAX_LINES records of seven hex fields
`include "router_defs.svh"

module tile_tb
    import router_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int       CLK_PERIOD = 100;
    localparam int       DRIVE_DLY  = 10;   // after the rising edge
    localparam int       FIELDS     = 7;    // per record
    localparam int       MAX_LINES  = 64;
    localparam t_tile_id OWN        = '{row: 2'd1, col: 2'd1};

    logic              clk;
    logic              arst_n;
    logic       [31:0] stim      [MAX_LINES*FIELDS];
    int                n_lines;
    logic              loaded;
    logic        [4:0] in_valid;          // index = t_cardinal
    t_tile_trans       in_req    [5];
    logic        [4:0] out_ready [5];     // lane readiness, [port][arbiter]
    logic        [4:0] out_valid;
    t_tile_trans       out_req   [5];
    logic        [4:0] in_ready  [5];     // downstream readiness per output
    logic       [31:0] rng;
    logic        [4:0] hold_out;          // outputs forced not ready
    t_tile_trans       exp_q     [25][$]; // [input*5 + output]
    int                n_sent;
    int                n_recv;
    int                n_checks;
    int                n_mismatch;
    int                n_other;

    tile_clkgen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (16)
    ) clkgen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    mini_core_tile mini_core_tile_i (
        .clk                 (clk),
        .arst_n              (arst_n),
        .local_tile_id       (OWN),
        .in_north_req_valid  (in_valid[NORTH]),
        .in_north_req        (in_req[NORTH]),
        .out_north_ready     (out_ready[NORTH]),
        .out_north_req_valid (out_valid[NORTH]),
        .out_north_req       (out_req[NORTH]),
        .in_north_ready      (in_ready[NORTH]),
        .in_east_req_valid   (in_valid[EAST]),
        .in_east_req         (in_req[EAST]),
        .out_east_ready      (out_ready[EAST]),
        .out_east_req_valid  (out_valid[EAST]),
        .out_east_req        (out_req[EAST]),
        .in_east_ready       (in_ready[EAST]),
        .in_south_req_valid  (in_valid[SOUTH]),
        .in_south_req        (in_req[SOUTH]),
        .out_south_ready     (out_ready[SOUTH]),
        .out_south_req_valid (out_valid[SOUTH]),
        .out_south_req       (out_req[SOUTH]),
        .in_south_ready      (in_ready[SOUTH]),
        .in_west_req_valid   (in_valid[WEST]),
        .in_west_req         (in_req[WEST]),
        .out_west_ready      (out_ready[WEST]),
        .out_west_req_valid  (out_valid[WEST]),
        .out_west_req        (out_req[WEST]),
        .in_west_ready       (in_ready[WEST]),
        .in_local_req_valid  (in_valid[LOCAL]),
        .in_local_req        (in_req[LOCAL]),
        .out_local_ready     (out_ready[LOCAL]),
        .out_local_req_valid (out_valid[LOCAL]),
        .out_local_req       (out_req[LOCAL]),
        .in_local_ready      (in_ready[LOCAL])
    );

    // ============================================================
    // helpers
    // ============================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] field(input int line, input int f);
        return stim[line*FIELDS + f];
    endfunction

    // one hop away, 0 north .. 3 west; 4 stays put
    function automatic t_tile_id step_to(input t_tile_id t, input int dir);
        t_tile_id n;
        n = t;
        case (dir)
            0: n.row = t.row - 2'd1;
            1: n.col = t.col + 2'd1;
            2: n.row = t.row + 2'd1;
            3: n.col = t.col - 2'd1;
            default: ;
        endcase
        return n;
    endfunction

    // XY: finish the column, then the row
    function automatic int xy_dir(input t_tile_id at, input t_tile_id dest);
        if (dest.col > at.col) return 1;
        if (dest.col < at.col) return 3;
        if (dest.row < at.row) return 0;
        if (dest.row > at.row) return 2;
        return 4;
    endfunction

    function automatic t_tile_trans make_trans(input int i, input logic [31:0] data_xor);
        t_tile_trans t;
        logic [31:0] w;
        w                       = field(i, 1);
        t.opcode                = t_opcode'(w[1:0]);
        t.address.flat          = field(i, 2);
        t.data                  = field(i, 3) ^ data_xor;
        t.requestor             = t_tile_id'(i[3:0]);  // tag only
        w                       = field(i, 4);
        t.next_tile_fifo_arb_id = t_cardinal'(w[2:0]);
        return t;
    endfunction

    // what the exit should show, lookahead taken from the file
    function automatic t_tile_trans expect_trans(input int i, input logic [31:0] data_xor);
        t_tile_trans t;
        logic [31:0] w;
        t                       = make_trans(i, data_xor);
        w                       = field(i, 6);
        t.next_tile_fifo_arb_id = t_cardinal'(w[2:0]);
        return t;
    endfunction

    task automatic check_val(input string name, input logic [127:0] exp_v,
                             input logic [127:0] act_v);
        n_checks++;
        if (exp_v !== act_v) begin
            n_mismatch++;
            $display("error at %0d ns: %s expected %0h actual %0h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic note_failure(input string msg);
        n_other++;
        $display("at %0d ns: %s", $time, msg);
    endtask

    // entered DRIVE_DLY after an edge, returns DRIVE_DLY after the transfer edge
    task automatic send_one(input int p, input int ex, input t_tile_trans t,
                            input t_tile_trans e);
        logic accepted;
        accepted    = 1'b0;
        in_req[p]   = t;
        in_valid[p] = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = out_ready[p][ex];  // ready only moves after an edge
            @(posedge clk);
        end
        exp_q[p*5 + ex].push_back(e);
        n_sent++;
        #DRIVE_DLY;
        in_valid[p] = 1'b0;
    endtask

    task automatic send_port(input int p);
        for (int i = 0; i < n_lines; i++) begin
            if (field(i, 0) == p) send_one(p, field(i, 5), make_trans(i, 0), expect_trans(i, 0));
        end
    endtask

    // head of one of the lanes feeding o must match, else order or routing broke
    task automatic match_output(input int o, input t_tile_trans got);
        int          hit;
        t_tile_trans e;
        hit = -1;
        for (int q = 0; q < 5; q++) begin
            if (hit < 0 && exp_q[q*5 + o].size() > 0) begin
                if (exp_q[q*5 + o][0].data == got.data) hit = q;
            end
        end
        n_recv++;
        if (hit < 0) begin
            note_failure($sformatf("output %0d delivered data %0h that no lane expects",
                                   o, got.data));
        end else begin
            e = exp_q[hit*5 + o].pop_front();
            check_val($sformatf("out_req[%0d].opcode", o), e.opcode, got.opcode);
            check_val($sformatf("out_req[%0d].address", o), e.address.flat, got.address.flat);
            check_val($sformatf("out_req[%0d].requestor", o), e.requestor, got.requestor);
            check_val($sformatf("out_req[%0d].next_tile_fifo_arb_id", o),
                      e.next_tile_fifo_arb_id, got.next_tile_fifo_arb_id);
        end
    endtask

    // ============================================================
    // downstream back-pressure
    // ============================================================
    initial begin : downstream
        rng = 32'h799ea996;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            rng = xorshift32(rng);
        end
    end

    always_comb begin
        for (int o = 0; o < 5; o++) begin
            in_ready[o] = rng[o*5 +: 5] & ~{5{hold_out[o]}};
        end
    end

    // transfers seen mid-cycle happen at the next edge
    initial begin : monitor
        forever begin
            @(negedge clk);
            for (int o = 0; o < 5; o++) begin
                if (arst_n && out_valid[o] && in_ready[o][out_req[o].next_tile_fifo_arb_id]) begin
                    match_output(o, out_req[o]);
                end
            end
        end
    end

    initial begin : watchdog
        wait (loaded === 1'b1);
        #((n_lines * 40 + 200) * CLK_PERIOD);
        $display("timeout: run still busy after %0d cycles", n_lines * 40 + 200);
        $display("Simulation FAILED");
        $finish;
    end

    // ============================================================
    // main sequence
    // ============================================================
    initial begin : main
        int          p;
        int          ex;
        int          ela;
        int          want_ex;
        int          want_la;
        int          left;
        int          n_assert;
        logic [31:0] w;
        t_tile_id    dest;
        logic        back;
        in_valid   = '0;
        hold_out   = '0;
        loaded     = 1'b0;
        n_lines    = 0;
        n_sent     = 0;
        n_recv     = 0;
        n_checks   = 0;
        n_mismatch = 0;
        n_other    = 0;
        for (int q = 0; q < 5; q++) in_req[q] = '0;
        // never a legal port number
        for (int a = 0; a < MAX_LINES*FIELDS; a++) stim[a] = 32'hffff_0000 | 32'(a);
        $readmemh("tests/tile_input.txt", stim);
        while (n_lines < MAX_LINES && field(n_lines, 0) <= 4) n_lines++;
        loaded = 1'b1;
        if (n_lines == 0) note_failure("input file holds no records");

        // cross-check the file against the XY rule
        for (int i = 0; i < n_lines; i++) begin
            p       = field(i, 0);
            ex      = field(i, 5);
            ela     = field(i, 6);
            w       = field(i, 2);
            dest    = t_tile_id'(w[31:28]);
            want_ex = (p == 4) ? xy_dir(OWN, dest) : int'(field(i, 4));
            want_la = (ex == 4) ? 4 : xy_dir(step_to(OWN, ex), dest);
            check_val($sformatf("input line %0d exit port", i + 1), want_ex, ex);
            check_val($sformatf("input line %0d exit lookahead", i + 1), want_la, ela);
            if (p == ex) note_failure($sformatf("input line %0d asks for a U-turn", i + 1));
        end

        wait (arst_n === 1'b1);
        @(negedge clk);
        for (int o = 0; o < 5; o++) begin
            check_val($sformatf("out_valid[%0d]", o), 1'b0, out_valid[o]);
            check_val($sformatf("out_ready[%0d]", o), 5'b11111 & ~(5'b1 << o), out_ready[o]);
        end

        if (n_lines > 0) begin
            // all five inputs at once
            @(posedge clk);
            #DRIVE_DLY;
            fork
                send_port(0);
                send_port(1);
                send_port(2);
                send_port(3);
                send_port(4);
            join
            wait (n_recv == n_sent);

            // stall the first record's exit and fill its lane
            @(posedge clk);
            #DRIVE_DLY;
            p            = field(0, 0);
            ex           = field(0, 5);
            hold_out[ex] = 1'b1;
            for (int k = 0; k < `TILE_FIFO_DEPTH + 1; k++) begin
                send_one(p, ex, make_trans(0, 32'h5a00_0001 + k),
                         expect_trans(0, 32'h5a00_0001 + k));
            end
            @(negedge clk);
            check_val($sformatf("out_ready[%0d][%0d] with lane full", p, ex),
                      1'b0, out_ready[p][ex]);
            @(posedge clk);
            #DRIVE_DLY;
            hold_out[ex] = 1'b0;
            back         = 1'b0;
            for (int c = 0; c < 8 && !back; c++) begin
                @(negedge clk);
                back = out_ready[p][ex];
            end
            if (!back) note_failure("lane ready stayed low after the output was released");
            wait (n_recv == n_sent);
        end

        left = 0;
        for (int q = 0; q < 25; q++) left += exp_q[q].size();
        if (left != 0) note_failure($sformatf("%0d transactions never left the tile", left));

        n_assert = mini_core_tile_i.u_router.checker_i.n_fail;
        $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 n_checks, n_mismatch, n_other, n_assert);
        if (n_mismatch == 0 && n_other == 0 && n_assert == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
